//--- hw/l2_geom_pkg.sv
`default_nettype none

package l2_geom_pkg;

    // set index width and set count
    localparam int INDEX = 4;
    localparam int DEPTH = 1 << INDEX;

    // way number width and associativity
    localparam int INDEX_WAY = 3;
    localparam int WAYS = 1 << INDEX_WAY;

    // tag sits above the set index in the request address
    localparam int TAG_W = 8;
    localparam int ADDR_W = TAG_W + INDEX;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX-1:0] set_t;
    typedef logic [INDEX_WAY-1:0] way_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

//--- hw/l2_ctrl_pkg.sv
`default_nettype none

package l2_ctrl_pkg;

    // two L1 clients share the tag controller
    localparam int N_PORTS = 2;

    // requester identifier carried with each lookup
    typedef logic [0:0] port_t;

    localparam port_t PORT_INSTR = 1'b0;
    localparam port_t PORT_DATA = 1'b1;

    // one lookup in flight, response two cycles after grant
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        RESPOND
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- hw/l2_lookup_if.sv
`timescale 1ns/10ps
`default_nettype none

interface l2_lookup_if;

    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;

    // request strobe from the arbiter, one cycle per grant
    logic req;
    port_t req_port;
    addr_t req_addr;

    // controller accepts only while idle
    logic ready;

    // response strobe, cannot be stalled
    logic resp_valid;
    port_t resp_port;
    logic resp_hit;
    way_t resp_way;
    logic resp_evict;
    tag_t resp_evict_tag;

    modport arb (
        output req,
        output req_port,
        output req_addr,
        input ready,
        input resp_valid,
        input resp_port,
        input resp_hit,
        input resp_way,
        input resp_evict,
        input resp_evict_tag
    );

    modport ctrl (
        input req,
        input req_port,
        input req_addr,
        output ready,
        output resp_valid,
        output resp_port,
        output resp_hit,
        output resp_way,
        output resp_evict,
        output resp_evict_tag
    );

endinterface

`default_nettype wire

//--- hw/l2_cache_plru.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_plru (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic valid_i,
    input wire l2_geom_pkg::set_t index_i,
    input wire l2_geom_pkg::way_t address_i,
    output l2_geom_pkg::way_t address_o
);

    import l2_geom_pkg::*;

    // tree of seven nodes per set
    //   level 0   root, picks lower or upper half
    //   level 1   two nodes, pick a pair
    //   level 2   four nodes, pick a way in the pair
    // a node bit holds the side that was last used
    // 0 means the lower-numbered child

    // update enables passed down the tree
    logic [1:0] en_l1;
    logic [3:0] en_l2;

    // node bits of the selected set
    logic bit_l0;
    logic [1:0] bit_l1;
    logic [3:0] bit_l2;

    way_t victim;

    // root takes the top address bit
    l2_cache_plru_node u_node_l0 (
        .clk_i(clk_i),
        .rst_ni(rst_ni),
        .valid_i(valid_i),
        .index_i(index_i),
        .value_i(address_i[2]),
        .load_left_o(en_l1[0]),
        .load_right_o(en_l1[1]),
        .load_o(bit_l0)
    );

    // middle level
    for (genvar i = 0; i < 2; i++) begin : g_level1
        l2_cache_plru_node u_node (
            .clk_i(clk_i),
            .rst_ni(rst_ni),
            .valid_i(en_l1[i]),
            .index_i(index_i),
            .value_i(address_i[1]),
            .load_left_o(en_l2[2*i]),
            .load_right_o(en_l2[2*i+1]),
            .load_o(bit_l1[i])
        );
    end

    // leaf level has no children to enable
    for (genvar i = 0; i < 4; i++) begin : g_level2
        l2_cache_plru_node u_node (
            .clk_i(clk_i),
            .rst_ni(rst_ni),
            .valid_i(en_l2[i]),
            .index_i(index_i),
            .value_i(address_i[0]),
            .load_left_o(),
            .load_right_o(),
            .load_o(bit_l2[i])
        );
    end

    // walk the inverted bits from the root
    always_comb begin
        victim[2] = ~bit_l0;
        victim[1] = ~bit_l1[victim[2]];
        victim[0] = ~bit_l2[victim[2:1]];
    end

    assign address_o = victim;

endmodule

module l2_cache_plru_node (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic valid_i,
    input wire l2_geom_pkg::set_t index_i,
    input wire logic value_i,
    output logic load_left_o,
    output logic load_right_o,
    output logic load_o
);

    import l2_geom_pkg::*;

    // one node bit per set
    logic [DEPTH-1:0] node_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            node_q <= '0;
        end else if (valid_i) begin
            node_q[index_i] <= value_i;
        end
    end

    // forward the update to the child on the accessed side
    assign load_left_o = valid_i && !value_i;
    assign load_right_o = valid_i && value_i;
    assign load_o = node_q[index_i];

endmodule

`default_nettype wire

//--- hw/l2_port_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module l2_port_arbiter (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic req0_i,
    input wire logic req1_i,
    input wire l2_geom_pkg::addr_t addr0_i,
    input wire l2_geom_pkg::addr_t addr1_i,
    l2_lookup_if.arb lookup,
    output logic gnt0_o,
    output logic gnt1_o,
    output logic resp0_valid_o,
    output logic resp0_hit_o,
    output l2_geom_pkg::way_t resp0_way_o,
    output logic resp0_evict_o,
    output l2_geom_pkg::tag_t resp0_evict_tag_o,
    output logic resp1_valid_o,
    output logic resp1_hit_o,
    output l2_geom_pkg::way_t resp1_way_o,
    output logic resp1_evict_o,
    output l2_geom_pkg::tag_t resp1_evict_tag_o
);

    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;

    logic [N_PORTS-1:0] req_vec;
    logic [N_PORTS-1:0] gnt_vec;
    logic [N_PORTS-1:0] rsp_sel;
    port_t last_q;
    port_t win;

    assign req_vec = {req1_i, req0_i};

    // on a tie the port not granted last wins
    always_comb begin
        if (&req_vec) begin
            win = ~last_q;
        end else if (req_vec[PORT_DATA]) begin
            win = PORT_DATA;
        end else begin
            win = PORT_INSTR;
        end
    end

    // grant and response select per port
    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            gnt_vec[p] = lookup.ready && req_vec[p] && (win == port_t'(p));
            rsp_sel[p] = lookup.resp_valid && (lookup.resp_port == port_t'(p));
        end
    end

    // request strobe only while the controller is idle
    assign lookup.req = lookup.ready && (|req_vec);
    assign lookup.req_port = win;
    assign lookup.req_addr = (win == PORT_DATA) ? addr1_i : addr0_i;

    // port 0 counts as last winner out of reset
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            last_q <= PORT_INSTR;
        end else if (lookup.req) begin
            last_q <= win;
        end
    end

    assign gnt0_o = gnt_vec[PORT_INSTR];
    assign gnt1_o = gnt_vec[PORT_DATA];

    // response fields zero unless the strobe belongs to this port
    assign resp0_valid_o = rsp_sel[PORT_INSTR];
    assign resp0_hit_o = rsp_sel[PORT_INSTR] && lookup.resp_hit;
    assign resp0_way_o = rsp_sel[PORT_INSTR] ? lookup.resp_way : '0;
    assign resp0_evict_o = rsp_sel[PORT_INSTR] && lookup.resp_evict;
    assign resp0_evict_tag_o = rsp_sel[PORT_INSTR] ? lookup.resp_evict_tag : '0;

    assign resp1_valid_o = rsp_sel[PORT_DATA];
    assign resp1_hit_o = rsp_sel[PORT_DATA] && lookup.resp_hit;
    assign resp1_way_o = rsp_sel[PORT_DATA] ? lookup.resp_way : '0;
    assign resp1_evict_o = rsp_sel[PORT_DATA] && lookup.resp_evict;
    assign resp1_evict_tag_o = rsp_sel[PORT_DATA] ? lookup.resp_evict_tag : '0;

endmodule

`default_nettype wire

//--- hw/l2_tag_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tag_ctrl (
    input wire logic clk_i,
    input wire logic rst_ni,
    l2_lookup_if.ctrl lookup
);

    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // captured request
    port_t port_q;
    addr_t addr_q;
    tag_t req_tag;
    set_t req_set;

    // tag store and valid bits
    tag_t tag_q [DEPTH][WAYS];
    logic [DEPTH-1:0][WAYS-1:0] valid_q;

    // lookup results
    logic [WAYS-1:0] hit_vec;
    logic hit;
    way_t hit_way;
    way_t victim;
    way_t use_way;
    logic evict;
    logic plru_upd;

    // registered response for the RESPOND cycle
    logic resp_hit_q;
    way_t resp_way_q;
    logic resp_evict_q;
    tag_t resp_evict_tag_q;

    // address split
    assign req_tag = addr_q[ADDR_W-1:INDEX];
    assign req_set = addr_q[INDEX-1:0];

    // IDLE -> LOOKUP -> RESPOND -> IDLE
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (lookup.req) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // take the request at the grant edge
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && lookup.req) begin
            port_q <= lookup.req_port;
            addr_q <= lookup.req_addr;
        end
    end

    // parallel compare over all ways of the set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[req_set][w] && (tag_q[req_set][w] == req_tag);
        end
    end

    assign hit = |hit_vec;

    // tags are unique in a set, so at most one way matches
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // miss takes the pLRU victim
    assign use_way = hit ? hit_way : victim;
    assign evict = !hit && valid_q[req_set][victim];
    assign plru_upd = (state_q == LOOKUP);

    l2_cache_plru u_plru (
        .clk_i(clk_i),
        .rst_ni(rst_ni),
        .valid_i(plru_upd),
        .index_i(req_set),
        .address_i(use_way),
        .address_o(victim)
    );

    // install the new tag on a miss
    always_ff @(posedge clk_i) begin
        if (plru_upd && !hit) begin
            tag_q[req_set][victim] <= req_tag;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (plru_upd && !hit) begin
            valid_q[req_set][victim] <= 1'b1;
        end
    end

    // hold lookup result for one cycle
    always_ff @(posedge clk_i) begin
        if (plru_upd) begin
            resp_hit_q <= hit;
            resp_way_q <= use_way;
            resp_evict_q <= evict;
            resp_evict_tag_q <= tag_q[req_set][victim];
        end
    end

    assign lookup.ready = (state_q == IDLE);
    assign lookup.resp_valid = (state_q == RESPOND);
    assign lookup.resp_port = port_q;
    assign lookup.resp_hit = resp_hit_q;
    assign lookup.resp_way = resp_way_q;
    assign lookup.resp_evict = resp_evict_q;
    assign lookup.resp_evict_tag = resp_evict_tag_q;

endmodule

`default_nettype wire

//--- hw/l2_cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_top (
    input wire logic clk_i,
    input wire logic rst_ni,
    // instruction refill client
    input wire logic req0_i,
    input wire l2_geom_pkg::addr_t addr0_i,
    output logic gnt0_o,
    output logic resp0_valid_o,
    output logic resp0_hit_o,
    output l2_geom_pkg::way_t resp0_way_o,
    output logic resp0_evict_o,
    output l2_geom_pkg::tag_t resp0_evict_tag_o,
    // data client
    input wire logic req1_i,
    input wire l2_geom_pkg::addr_t addr1_i,
    output logic gnt1_o,
    output logic resp1_valid_o,
    output logic resp1_hit_o,
    output l2_geom_pkg::way_t resp1_way_o,
    output logic resp1_evict_o,
    output l2_geom_pkg::tag_t resp1_evict_tag_o
);

    // arbiter to tag controller
    l2_lookup_if lookup_bus ();

    l2_port_arbiter u_arbiter (
        .clk_i(clk_i),
        .rst_ni(rst_ni),
        .req0_i(req0_i),
        .req1_i(req1_i),
        .addr0_i(addr0_i),
        .addr1_i(addr1_i),
        .lookup(lookup_bus.arb),
        .gnt0_o(gnt0_o),
        .gnt1_o(gnt1_o),
        .resp0_valid_o(resp0_valid_o),
        .resp0_hit_o(resp0_hit_o),
        .resp0_way_o(resp0_way_o),
        .resp0_evict_o(resp0_evict_o),
        .resp0_evict_tag_o(resp0_evict_tag_o),
        .resp1_valid_o(resp1_valid_o),
        .resp1_hit_o(resp1_hit_o),
        .resp1_way_o(resp1_way_o),
        .resp1_evict_o(resp1_evict_o),
        .resp1_evict_tag_o(resp1_evict_tag_o)
    );

    l2_tag_ctrl u_tag_ctrl (
        .clk_i(clk_i),
        .rst_ni(rst_ni),
        .lookup(lookup_bus.ctrl)
    );

endmodule

`default_nettype wire

//--- testbench/l2_cache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_checker (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic req0_i,
    input wire logic req1_i,
    input wire logic gnt0_o,
    input wire logic gnt1_o,
    input wire logic resp0_valid_o,
    input wire logic resp1_valid_o
);

    // one winner per cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(gnt0_o && gnt1_o))
        else $error("both grants high in one cycle");

    // no grant without a pending request
    assert property (@(posedge clk_i) disable iff (!rst_ni) gnt0_o |-> req0_i)
        else $error("gnt0_o without req0_i");
    assert property (@(posedge clk_i) disable iff (!rst_ni) gnt1_o |-> req1_i)
        else $error("gnt1_o without req1_i");

    // response two cycles after the grant, on the granted port only
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt0_o |-> ##2 (resp0_valid_o && !resp1_valid_o))
        else $error("port 0 response not seen two cycles after grant");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt1_o |-> ##2 (resp1_valid_o && !resp0_valid_o))
        else $error("port 1 response not seen two cycles after grant");

    // quiet outputs while reset is held
    assert property (@(posedge clk_i) (!rst_ni && $past(!rst_ni)) |->
        !(gnt0_o || gnt1_o || resp0_valid_o || resp1_valid_o))
        else $error("grant or response during reset");

endmodule

bind l2_cache_top l2_cache_checker u_checker (.*);

`default_nettype wire

//--- testbench/l2_cache_model.svh
`ifndef L2_CACHE_MODEL_SVH
`define L2_CACHE_MODEL_SVH

// shadow copy of tags, valid bits and tree nodes per set
tag_t m_tag [DEPTH][WAYS];
logic [WAYS-1:0] m_valid [DEPTH];
// node 0 root, 1..2 middle, 3..6 leaves
logic [6:0] m_node [DEPTH];

task automatic model_reset();
    for (int s = 0; s < DEPTH; s++) begin
        m_valid[s] = '0;
        m_node[s] = '0;
    end
endtask

// follow the inverted node bits from the root
function automatic way_t model_victim(input set_t s);
    way_t v;
    v[2] = ~m_node[s][0];
    v[1] = ~m_node[s][1 + int'(v[2])];
    v[0] = ~m_node[s][3 + int'({v[2], v[1]})];
    return v;
endfunction

// one lookup as the cache should see it
task automatic model_access(input addr_t a, output logic hit, output way_t way,
                            output logic ev, output tag_t ev_tag);
    tag_t t;
    set_t s;
    t = a[ADDR_W-1:INDEX];
    s = a[INDEX-1:0];
    hit = 1'b0;
    way = '0;
    ev = 1'b0;
    ev_tag = '0;
    for (int w = 0; w < WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == t) begin
            hit = 1'b1;
            way = way_t'(w);
        end
    end
    // miss allocates the victim and reports what it held
    if (!hit) begin
        way = model_victim(s);
        ev = m_valid[s][way];
        ev_tag = m_tag[s][way];
        m_tag[s][way] = t;
        m_valid[s][way] = 1'b1;
    end
    // accessed path goes into the nodes
    m_node[s][0] = way[2];
    m_node[s][1 + int'(way[2])] = way[1];
    m_node[s][3 + int'(way[2:1])] = way[0];
endtask

`endif

//--- testbench/l2_cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb;

    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;

    // requests issued per test
    localparam int N_FILL = 9;
    localparam int N_ALT = 8;
    localparam int N_RAND = 320;
    localparam int N_REQ = 2 + 3 + N_FILL + N_ALT + N_RAND;
    // eight cycles per request, two resets, slack
    localparam int TIMEOUT_CYC = N_REQ * 8 + 2 * 8 + 100;

    typedef struct packed {
        port_t port;
        logic hit;
        way_t way;
        logic evict;
        tag_t evict_tag;
        int due;
    } exp_t;

    logic clk_i;
    logic rst_ni;
    logic req0_i, req1_i;
    addr_t addr0_i, addr1_i;
    logic gnt0_o, gnt1_o;
    logic resp0_valid_o, resp1_valid_o;
    logic resp0_hit_o, resp1_hit_o;
    way_t resp0_way_o, resp1_way_o;
    logic resp0_evict_o, resp1_evict_o;
    tag_t resp0_evict_tag_o, resp1_evict_tag_o;

    // outstanding lookups and grant order
    exp_t pending [$];
    port_t gnt_hist [$];
    int cyc = 0;
    int err_count = 0;
    int err_start = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;
    // last response seen, for direct checks in the tests
    logic last_hit;
    way_t last_way;
    logic last_evict;
    tag_t last_evict_tag;

    `include "l2_cache_model.svh"

    l2_cache_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            $display("ERR %s exp=%h got=%h", name, exp, got);
            err_count++;
        end
    endtask

    task automatic check_resp(input exp_t e);
        string pfx;
        logic v, other_v, hit, ev;
        way_t way;
        tag_t ev_tag;
        pfx = $sformatf("resp%0d", e.port);
        if (e.port == PORT_DATA) begin
            v = resp1_valid_o;
            other_v = resp0_valid_o;
            hit = resp1_hit_o;
            way = resp1_way_o;
            ev = resp1_evict_o;
            ev_tag = resp1_evict_tag_o;
        end else begin
            v = resp0_valid_o;
            other_v = resp1_valid_o;
            hit = resp0_hit_o;
            way = resp0_way_o;
            ev = resp0_evict_o;
            ev_tag = resp0_evict_tag_o;
        end
        compare_field({pfx, "_valid_o"}, 1, v);
        compare_field($sformatf("resp%0d_valid_o", 1 - e.port), 0, other_v);
        compare_field({pfx, "_hit_o"}, e.hit, hit);
        compare_field({pfx, "_way_o"}, e.way, way);
        compare_field({pfx, "_evict_o"}, e.evict, ev);
        // displaced tag only means something on an eviction
        if (e.evict) begin
            compare_field({pfx, "_evict_tag_o"}, e.evict_tag, ev_tag);
        end
        last_hit = hit;
        last_way = way;
        last_evict = ev;
        last_evict_tag = ev_tag;
    endtask

    // model steps at the grant, same order as the controller
    task automatic note_grant(input port_t p, input addr_t a);
        exp_t e;
        logic hit, ev;
        way_t way;
        tag_t ev_tag;
        model_access(a, hit, way, ev, ev_tag);
        e.port = p;
        e.hit = hit;
        e.way = way;
        e.evict = ev;
        e.evict_tag = ev_tag;
        e.due = cyc + 2;
        pending.push_back(e);
        gnt_hist.push_back(p);
    endtask

    // sample at the rising edge, outputs settled since the last one
    always @(posedge clk_i) begin : monitor
        exp_t e;
        logic [1:0] rv;
        if (rst_ni) begin
            rv = {resp1_valid_o, resp0_valid_o};
            while (pending.size() > 0 && pending[0].due < cyc) begin
                e = pending.pop_front();
                $display("no response on port %0d two cycles after its grant", e.port);
                err_count++;
            end
            if (rv != 2'b00) begin
                if (pending.size() == 0 || pending[0].due != cyc) begin
                    $display("response strobe %b without a grant two cycles before", rv);
                    err_count++;
                end else begin
                    e = pending.pop_front();
                    check_resp(e);
                end
            end
            if (gnt0_o) begin
                note_grant(PORT_INSTR, addr0_i);
            end
            if (gnt1_o) begin
                note_grant(PORT_DATA, addr1_i);
            end
        end
        cyc++;
        if (cyc > TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, a grant or response never came", cyc);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic wait_idle();
        while (pending.size() > 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        rst_ni = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        model_reset();
        pending.delete();
        gnt_hist.delete();
    endtask

    // hold the request until granted, then wait for the response
    task automatic send_request(input int port, input addr_t a);
        @(negedge clk_i);
        if (port == 0) begin
            req0_i = 1'b1;
            addr0_i = a;
        end else begin
            req1_i = 1'b1;
            addr1_i = a;
        end
        do begin
            @(posedge clk_i);
        end while (!(port == 0 ? gnt0_o : gnt1_o));
        @(negedge clk_i);
        req0_i = 1'b0;
        req1_i = 1'b0;
        wait_idle();
    endtask

    // twelve tags over three sets forces evictions
    function automatic addr_t random_addr();
        tag_t t;
        set_t s;
        t = tag_t'(8'ha0 + ($urandom % 12));
        s = set_t'(4 + ($urandom % 3));
        return {t, s};
    endfunction

    task automatic start_test();
        err_start = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == err_start) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_count - err_start);
        end
    endtask

    initial begin
        way_t alloc;
        way_t first_way;
        logic [WAYS-1:0] used;
        logic g0, g1;
        int n;
        void'($urandom(32'h501d31fd));
        rst_ni = 1'b0;
        req0_i = 1'b0;
        req1_i = 1'b0;
        addr0_i = '0;
        addr1_i = '0;
        apply_reset();

        // fresh set, tree gives way 7 then way 3
        start_test();
        send_request(0, {8'h11, 4'd5});
        compare_field("resp0_way_o", 7, last_way);
        compare_field("resp0_evict_o", 0, last_evict);
        send_request(1, {8'h12, 4'd5});
        compare_field("resp1_way_o", 3, last_way);
        compare_field("resp1_evict_o", 0, last_evict);
        end_test("first_misses");

        // refill then hit from both ports
        start_test();
        // way the model allocates for the first miss
        alloc = model_victim(4'd9);
        send_request(0, {8'h22, 4'd9});
        send_request(1, {8'h22, 4'd9});
        compare_field("resp1_hit_o", 1, last_hit);
        compare_field("resp1_way_o", alloc, last_way);
        send_request(0, {8'h22, 4'd9});
        compare_field("resp0_hit_o", 1, last_hit);
        compare_field("resp0_way_o", alloc, last_way);
        end_test("miss_then_hit");

        // eight fills then an eviction of the oldest line
        start_test();
        used = '0;
        // first fill goes where the model points in the fresh set
        first_way = model_victim(4'd2);
        for (int i = 0; i < N_FILL - 1; i++) begin
            send_request(i % 2, {tag_t'(8'h40 + i), 4'd2});
            compare_field($sformatf("resp%0d_evict_o", i % 2), 0, last_evict);
            used[last_way] = 1'b1;
        end
        if (used !== '1) begin
            $display("fills did not cover all eight ways, mask %h", used);
            err_count++;
        end
        send_request(0, {8'h48, 4'd2});
        compare_field("resp0_evict_o", 1, last_evict);
        compare_field("resp0_evict_tag_o", 8'h40, last_evict_tag);
        compare_field("resp0_way_o", first_way, last_way);
        end_test("fill_and_evict");

        // both ports requesting, grants alternate from port 1
        apply_reset();
        start_test();
        @(negedge clk_i);
        req0_i = 1'b1;
        addr0_i = random_addr();
        req1_i = 1'b1;
        addr1_i = random_addr();
        n = 0;
        while (n < N_ALT) begin
            @(posedge clk_i);
            g0 = gnt0_o;
            g1 = gnt1_o;
            @(negedge clk_i);
            if (g0) begin
                addr0_i = random_addr();
            end
            if (g1) begin
                addr1_i = random_addr();
            end
            if (g0 || g1) begin
                n++;
            end
        end
        req0_i = 1'b0;
        req1_i = 1'b0;
        wait_idle();
        if (gnt_hist.size() != N_ALT) begin
            $display("saw %0d grants where %0d were expected", gnt_hist.size(), N_ALT);
            err_count++;
        end
        for (int i = 0; i < gnt_hist.size(); i++) begin
            if (gnt_hist[i] !== port_t'((i + 1) % 2)) begin
                $display("ERR gnt port at grant %0d exp=%h got=%h", i, (i + 1) % 2,
                         gnt_hist[i]);
                err_count++;
            end
        end
        end_test("alternating_grants");

        // random traffic on both ports against the model
        start_test();
        n = 0;
        while (n < N_RAND) begin
            @(posedge clk_i);
            g0 = gnt0_o;
            g1 = gnt1_o;
            @(negedge clk_i);
            if (g0) begin
                req0_i = 1'b0;
            end
            if (g1) begin
                req1_i = 1'b0;
            end
            n += int'(g0) + int'(g1);
            // never more outstanding than the request budget
            if (!req0_i && (n + int'(req1_i)) < N_RAND && ($urandom % 2) == 1) begin
                req0_i = 1'b1;
                addr0_i = random_addr();
            end
            if (!req1_i && (n + int'(req0_i)) < N_RAND && ($urandom % 2) == 1) begin
                req1_i = 1'b1;
                addr1_i = random_addr();
            end
        end
        wait_idle();
        end_test("random_traffic");

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
hw/l2_geom_pkg.sv
hw/l2_ctrl_pkg.sv
hw/l2_lookup_if.sv
hw/l2_cache_plru.sv
hw/l2_port_arbiter.sv
hw/l2_tag_ctrl.sv
hw/l2_cache_top.sv
testbench/l2_cache_checker.sv
testbench/l2_cache_tb.sv
